// ==== source/uart_pkg.sv ====
package uart_pkg;

    // Defaults for the top level parameters
    localparam int DEF_ADDR_WIDTH = 32;
    localparam int DEF_DATA_WIDTH = 32;

    localparam int LEN_WIDTH = 4;  // Data length field in CR

    // Register word index, address bits above the byte lane
    typedef enum logic [11:0] {
        DR  = 12'd0,
        CR  = 12'd1,
        SR  = 12'd2,
        BRR = 12'd3,
        IER = 12'd4
    } reg_index_e;

    // Frame position, same walk for transmitter and receiver
    typedef enum logic [2:0] {
        IDLE,
        START,
        DATA,
        PARITY,
        STOP
    } line_state_e;

    // CR bit positions
    localparam int CR_ENABLE  = 0;
    localparam int CR_TX_EN   = 1;
    localparam int CR_RX_EN   = 2;
    localparam int CR_PAR_EN  = 3;
    localparam int CR_PAR_ODD = 4;
    localparam int CR_STOP2   = 5;
    localparam int CR_LEN_LSB = 8;   // Field runs 8 to 11

endpackage

// ==== source/uart_cfg_if.sv ====
`timescale 1ns/1ns

interface uart_cfg_if #(
    parameter int DATA_WIDTH = uart_pkg::DEF_DATA_WIDTH
);
    logic                           parity_control;  // Parity bit present
    logic                           parity_select;   // Odd parity when set
    logic                           stop_bits;       // Two stop bits when set
    logic [uart_pkg::LEN_WIDTH-1:0] data_length;     // Data bits per frame
    logic [DATA_WIDTH-1:0]          baud_rate;       // Bit time minus one

    modport source (
        output parity_control, parity_select, stop_bits, data_length, baud_rate
    );

    modport sink (
        input parity_control, parity_select, stop_bits, data_length, baud_rate
    );

endinterface

// ==== source/uart_regs.sv ====
`timescale 1ns/1ns

module uart_regs #(
    parameter int ADDR_WIDTH = uart_pkg::DEF_ADDR_WIDTH,
    parameter int DATA_WIDTH = uart_pkg::DEF_DATA_WIDTH
) (
    input  logic                    seq,
    input  logic                    reset,
    input  logic [ADDR_WIDTH-1:0]   paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [DATA_WIDTH-1:0]   pwdata,
    input  logic [DATA_WIDTH/8-1:0] pstrb,
    output logic                    pready,
    output logic [DATA_WIDTH-1:0]   prdata,
    output logic                    pslverr,
    input  logic                    pause_req,
    output logic                    pause_ack,
    output logic                    irq,
    uart_cfg_if.source              cfg,
    output logic [DATA_WIDTH-1:0]   tx_data,
    output logic                    tx_valid,
    input  logic                    tx_ready,
    input  logic [DATA_WIDTH-1:0]   rx_data,
    input  logic                    rx_valid,
    output logic                    rx_ready,
    output logic                    tx_pause_req,
    output logic                    rx_pause_req,
    input  logic                    tx_pause_ack,
    input  logic                    rx_pause_ack
);

    localparam int ADDR_LSB = $clog2(DATA_WIDTH / 8);

    logic [ADDR_WIDTH-ADDR_LSB-1:0] index;
    logic [DATA_WIDTH-1:0] mask;
    logic [DATA_WIDTH-1:0] cr;
    logic [DATA_WIDTH-1:0] brr;
    logic [DATA_WIDTH-1:0] ier;
    logic [DATA_WIDTH-1:0] status;
    logic [DATA_WIDTH-1:0] new_cr;
    logic [DATA_WIDTH-1:0] tx_buf;
    logic [DATA_WIDTH-1:0] rx_buf;
    logic tx_empty;
    logic rx_full;
    logic cfg_hold;        // Engines parked for a CR update or while disabled
    logic ext_hold;        // External pause in force
    logic engines_parked;
    logic access;          // Setup seen, no response given yet
    logic live_change;

    always_comb begin
        index = paddr[ADDR_WIDTH-1:ADDR_LSB];
        for (int i = 0; i < DATA_WIDTH / 8; i++) begin
            mask[i*8 +: 8] = {8{pstrb[i]}};
        end
        new_cr = (pwdata & mask) | (cr & ~mask);

        // Touches the line while running, engines must stop first
        live_change = (new_cr != cr) &&
                      (new_cr[uart_pkg::CR_ENABLE] || cr[uart_pkg::CR_ENABLE]);

        status    = '0;
        status[0] = tx_empty;
        status[1] = rx_full;
    end

    assign cfg.parity_control = cr[uart_pkg::CR_PAR_EN];
    assign cfg.parity_select  = cr[uart_pkg::CR_PAR_ODD];
    assign cfg.stop_bits      = cr[uart_pkg::CR_STOP2];
    assign cfg.data_length    = cr[uart_pkg::CR_LEN_LSB +: uart_pkg::LEN_WIDTH];
    assign cfg.baud_rate      = brr;

    assign tx_data  = tx_buf;
    assign tx_valid = !tx_empty;
    assign rx_ready = !rx_full;

    assign tx_pause_req   = cfg_hold || ext_hold;
    assign rx_pause_req   = cfg_hold || ext_hold;
    assign engines_parked = tx_pause_ack && rx_pause_ack;
    assign access         = psel && !pready;

    assign irq = cr[uart_pkg::CR_ENABLE] && !ext_hold && !pause_ack &&
                 ((tx_empty && ier[0]) || (rx_full && ier[1]));

    always_ff @(posedge seq) begin
        if (reset) begin
            cr        <= '0;
            brr       <= '0;
            ier       <= '0;
            tx_empty  <= 1'b1;
            rx_full   <= 1'b0;
            cfg_hold  <= 1'b1;   // Parked until the first CR write
            ext_hold  <= 1'b0;
            pause_ack <= 1'b0;
            pready    <= 1'b0;
            pslverr   <= 1'b0;
            prdata    <= '0;
        end else begin
            if (access && ext_hold) begin
                pready  <= 1'b1;
                pslverr <= 1'b1;
            end else if (access) begin
                pready <= 1'b1;   // CR wait below pulls it back
                case (index)
                    uart_pkg::DR: begin
                        if (pwrite && cr[uart_pkg::CR_ENABLE] && cr[uart_pkg::CR_TX_EN] &&
                            tx_empty) begin
                            tx_buf   <= pwdata;
                            tx_empty <= 1'b0;
                        end else if (!pwrite && cr[uart_pkg::CR_ENABLE] &&
                                     cr[uart_pkg::CR_RX_EN] && rx_full) begin
                            prdata  <= rx_buf;
                            rx_full <= 1'b0;
                        end else begin
                            pslverr <= 1'b1;
                        end
                    end
                    uart_pkg::CR: begin
                        if (!pwrite) begin
                            prdata <= cr;
                        end else if (live_change && !(cfg_hold && engines_parked)) begin
                            cfg_hold <= 1'b1;   // Wait for both engines
                            pready   <= 1'b0;
                        end else begin
                            cr       <= new_cr;
                            cfg_hold <= !new_cr[uart_pkg::CR_ENABLE];
                        end
                    end
                    uart_pkg::SR: begin
                        if (pwrite) begin
                            pslverr <= 1'b1;   // Read only
                        end else begin
                            prdata <= status;
                        end
                    end
                    uart_pkg::BRR: begin
                        if (pwrite) begin
                            brr <= (pwdata & mask) | (brr & ~mask);
                        end else begin
                            prdata <= brr;
                        end
                    end
                    uart_pkg::IER: begin
                        if (pwrite) begin
                            ier <= (pwdata & mask) | (ier & ~mask);
                        end else begin
                            prdata <= ier;
                        end
                    end
                    default: pslverr <= 1'b1;
                endcase
            end else if (psel && penable && pready) begin
                pready  <= 1'b0;
                pslverr <= 1'b0;
                prdata  <= '0;
            end

            // External pause, taken between APB transfers only
            if (pause_req && !ext_hold && !pause_ack && !access) begin
                ext_hold <= 1'b1;
            end else if (!pause_req) begin
                ext_hold <= 1'b0;
            end

            if (pause_req && ext_hold && engines_parked) begin
                pause_ack <= 1'b1;
            end else if (!pause_req && !ext_hold &&
                         (cfg_hold || (!tx_pause_ack && !rx_pause_ack))) begin
                pause_ack <= 1'b0;   // Engines back to their own state
            end

            // Engine handshakes never collide with the APB side above
            if (tx_valid && tx_ready) begin
                tx_empty <= 1'b1;
            end
            if (rx_valid && rx_ready) begin
                rx_buf  <= rx_data;
                rx_full <= 1'b1;
            end
        end
    end

endmodule

// ==== source/uart_tx.sv ====
`timescale 1ns/1ns

module uart_tx #(
    parameter int DATA_WIDTH = uart_pkg::DEF_DATA_WIDTH
) (
    input  logic                  seq,
    input  logic                  reset,
    uart_cfg_if.sink              cfg,
    input  logic [DATA_WIDTH-1:0] tx_data,
    input  logic                  tx_valid,
    output logic                  tx_ready,
    input  logic                  pause_req,
    output logic                  pause_ack,
    output logic                  tx
);

    uart_pkg::line_state_e state;

    logic [DATA_WIDTH-1:0] baud_cnt;
    logic [3:0]            bit_cnt;
    logic [DATA_WIDTH-1:0] shreg;
    logic                  par_bit;
    logic [DATA_WIDTH-1:0] len_mask;
    logic                  bit_done;

    assign len_mask = ~({DATA_WIDTH{1'b1}} << cfg.data_length);
    assign bit_done = (baud_cnt == cfg.baud_rate);
    assign tx_ready = (state == uart_pkg::IDLE) && !pause_req && !pause_ack;

    always_comb begin
        case (state)
            uart_pkg::START:  tx = 1'b0;
            uart_pkg::DATA:   tx = shreg[0];   // LSB first
            uart_pkg::PARITY: tx = par_bit;
            default:          tx = 1'b1;       // Idle and stop bits
        endcase
    end

    always_ff @(posedge seq) begin
        if (reset) begin
            state     <= uart_pkg::IDLE;
            baud_cnt  <= '0;
            bit_cnt   <= '0;
            pause_ack <= 1'b0;
        end else begin
            if (!pause_req) begin
                pause_ack <= 1'b0;
            end else if (state == uart_pkg::IDLE) begin
                pause_ack <= 1'b1;
            end

            if (state == uart_pkg::IDLE) begin
                baud_cnt <= '0;
                bit_cnt  <= '0;
                if (tx_valid && tx_ready) begin
                    shreg   <= tx_data;
                    par_bit <= (^(tx_data & len_mask)) ^ cfg.parity_select;
                    state   <= uart_pkg::START;
                end
            end else if (!bit_done) begin
                baud_cnt <= baud_cnt + 1'b1;
            end else begin
                baud_cnt <= '0;
                case (state)
                    uart_pkg::START: state <= uart_pkg::DATA;
                    uart_pkg::DATA: begin
                        shreg <= shreg >> 1;
                        if (bit_cnt == cfg.data_length - 4'd1) begin
                            bit_cnt <= '0;
                            state   <= cfg.parity_control ? uart_pkg::PARITY : uart_pkg::STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                    uart_pkg::PARITY: state <= uart_pkg::STOP;
                    default: begin
                        if (cfg.stop_bits && bit_cnt == 4'd0) begin
                            bit_cnt <= 4'd1;   // Second stop bit
                        end else begin
                            state <= uart_pkg::IDLE;
                        end
                    end
                endcase
            end
        end
    end

endmodule

// ==== source/uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx #(
    parameter int DATA_WIDTH = uart_pkg::DEF_DATA_WIDTH
) (
    input  logic                  seq,
    input  logic                  reset,
    uart_cfg_if.sink              cfg,
    input  logic                  rx,
    output logic [DATA_WIDTH-1:0] rx_data,
    output logic                  rx_valid,
    input  logic                  rx_ready,
    input  logic                  pause_req,
    output logic                  pause_ack
);

    uart_pkg::line_state_e state;

    logic                  rx_meta;
    logic                  rx_sync;
    logic                  rx_prev;
    logic [DATA_WIDTH-1:0] baud_cnt;
    logic [3:0]            bit_cnt;
    logic [DATA_WIDTH-1:0] shreg;
    logic                  par_acc;
    logic                  frame_ok;
    logic                  sample;

    // Half a bit into the start bit, then once per bit
    assign sample = (state == uart_pkg::START) ? (baud_cnt == (cfg.baud_rate >> 1))
                                               : (baud_cnt == cfg.baud_rate);

    always_ff @(posedge seq) begin
        if (reset) begin
            rx_meta   <= 1'b1;
            rx_sync   <= 1'b1;
            rx_prev   <= 1'b1;
            state     <= uart_pkg::IDLE;
            baud_cnt  <= '0;
            bit_cnt   <= '0;
            rx_valid  <= 1'b0;
            pause_ack <= 1'b0;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;

            if (!pause_req) begin
                pause_ack <= 1'b0;
            end else if (state == uart_pkg::IDLE) begin
                pause_ack <= 1'b1;
            end

            if (rx_valid && rx_ready) begin
                rx_valid <= 1'b0;
            end

            if (state == uart_pkg::IDLE) begin
                baud_cnt <= '0;
                bit_cnt  <= '0;
                if (rx_prev && !rx_sync && !pause_req && !pause_ack) begin
                    shreg    <= '0;
                    par_acc  <= 1'b0;
                    frame_ok <= 1'b1;
                    state    <= uart_pkg::START;
                end
            end else if (!sample) begin
                baud_cnt <= baud_cnt + 1'b1;
            end else begin
                baud_cnt <= '0;
                case (state)
                    uart_pkg::START: begin
                        // Glitch if the line is already back high
                        state <= rx_sync ? uart_pkg::IDLE : uart_pkg::DATA;
                    end
                    uart_pkg::DATA: begin
                        shreg[bit_cnt] <= rx_sync;
                        par_acc        <= par_acc ^ rx_sync;
                        if (bit_cnt == cfg.data_length - 4'd1) begin
                            bit_cnt <= '0;
                            state   <= cfg.parity_control ? uart_pkg::PARITY : uart_pkg::STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                    uart_pkg::PARITY: begin
                        if (par_acc ^ rx_sync ^ cfg.parity_select) begin
                            frame_ok <= 1'b0;
                        end
                        state <= uart_pkg::STOP;
                    end
                    default: begin
                        if (cfg.stop_bits && bit_cnt == 4'd0) begin
                            bit_cnt  <= 4'd1;
                            frame_ok <= frame_ok && rx_sync;
                        end else begin
                            state <= uart_pkg::IDLE;
                            // Bad frame, or previous word still waiting
                            if (frame_ok && rx_sync && !rx_valid) begin
                                rx_data  <= shreg;
                                rx_valid <= 1'b1;
                            end
                        end
                    end
                endcase
            end
        end
    end

endmodule

// ==== source/uart_periph.sv ====
`timescale 1ns/1ns

module uart_periph #(
    parameter int ADDR_WIDTH = uart_pkg::DEF_ADDR_WIDTH,
    parameter int DATA_WIDTH = uart_pkg::DEF_DATA_WIDTH
) (
    input  logic                    seq,
    input  logic                    reset,
    input  logic [ADDR_WIDTH-1:0]   paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [DATA_WIDTH-1:0]   pwdata,
    input  logic [DATA_WIDTH/8-1:0] pstrb,
    output logic                    pready,
    output logic [DATA_WIDTH-1:0]   prdata,
    output logic                    pslverr,
    input  logic                    pause_req,
    output logic                    pause_ack,
    output logic                    irq,
    output logic                    tx,
    input  logic                    rx
);

    logic [DATA_WIDTH-1:0] tx_data;
    logic                  tx_valid;
    logic                  tx_ready;
    logic [DATA_WIDTH-1:0] rx_data;
    logic                  rx_valid;
    logic                  rx_ready;
    logic                  tx_pause_req;
    logic                  tx_pause_ack;
    logic                  rx_pause_req;
    logic                  rx_pause_ack;

    uart_cfg_if #(.DATA_WIDTH(DATA_WIDTH)) cfg ();

    uart_regs #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) regs0 (
        .seq          (seq),
        .reset        (reset),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .pstrb        (pstrb),
        .pready       (pready),
        .prdata       (prdata),
        .pslverr      (pslverr),
        .pause_req    (pause_req),
        .pause_ack    (pause_ack),
        .irq          (irq),
        .cfg          (cfg.source),
        .tx_data      (tx_data),
        .tx_valid     (tx_valid),
        .tx_ready     (tx_ready),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_ready     (rx_ready),
        .tx_pause_req (tx_pause_req),
        .rx_pause_req (rx_pause_req),
        .tx_pause_ack (tx_pause_ack),
        .rx_pause_ack (rx_pause_ack)
    );

    uart_tx #(.DATA_WIDTH(DATA_WIDTH)) tx0 (
        .seq       (seq),
        .reset     (reset),
        .cfg       (cfg.sink),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .pause_req (tx_pause_req),
        .pause_ack (tx_pause_ack),
        .tx        (tx)
    );

    uart_rx #(.DATA_WIDTH(DATA_WIDTH)) rx0 (
        .seq       (seq),
        .reset     (reset),
        .cfg       (cfg.sink),
        .rx        (rx),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .pause_req (rx_pause_req),
        .pause_ack (rx_pause_ack)
    );

endmodule

// ==== verification/uart_tb.sv ====
`timescale 1ns/1ns

module uart_tb;

    localparam int BRR_VAL     = 7;
    localparam int BIT_CYCLES  = BRR_VAL + 1;
    localparam int CYCLE_LIMIT = 20000;  // About 40 frames of 12 bits plus APB traffic

    logic        seq = 1'b0;
    logic        reset;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [3:0]  pstrb;
    logic        pready;
    logic [31:0] prdata;
    logic        pslverr;
    logic        pause_req;
    logic        pause_ack;
    logic        irq;
    wire         tx_line;  // Serial loopback, tx straight into rx

    integer seed = 69;
    int cycles = 0;
    int err_count = 0;
    int err_mark = 0;
    int tests_run = 0;
    int tests_failed = 0;

    // Line setting currently in CR
    int   cur_len = 8;
    logic cur_par = 1'b0;
    logic cur_odd = 1'b0;
    logic cur_stop2 = 1'b0;

    // Flags that arm the assertions, and their expected values
    logic        chk_err = 1'b0;
    logic        exp_err = 1'b0;
    logic        chk_rd = 1'b0;
    logic [31:0] exp_rdata = '0;
    logic        t_frame = 1'b0;
    logic        bit_strobe = 1'b0;
    logic        exp_bit = 1'b1;
    int          bit_index = 0;
    logic        t_idle = 1'b0;
    logic        t_irq = 1'b0;
    logic        exp_irq = 1'b0;
    logic        t_pause = 1'b0;

    always #2 seq = ~seq;

    uart_periph #(.ADDR_WIDTH(32), .DATA_WIDTH(32)) dut0 (
        .seq       (seq),
        .reset     (reset),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .pready    (pready),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .irq       (irq),
        .tx        (tx_line),
        .rx        (tx_line)
    );

    always @(posedge seq) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run stopped after %0d cycles, the DUT stopped responding", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    assert property (@(posedge seq) disable iff (reset) (psel && penable && pready) |=> !pready)
        else begin
            err_count++;
            $display("** Error at %0t ns: pready = 1, expected 0 after a completed transfer",
                     $time);
        end

    assert property (@(posedge seq) (chk_err && psel && penable && pready) |-> pslverr == exp_err)
        else begin
            err_count++;
            $display("** Error at %0t ns: pslverr = %b, expected %b",
                     $time, $sampled(pslverr), $sampled(exp_err));
        end

    assert property (@(posedge seq) (chk_rd && psel && penable && pready && !pwrite) |->
                     prdata == exp_rdata)
        else begin
            err_count++;
            $display("** Error at %0t ns: prdata = %h, expected %h",
                     $time, $sampled(prdata), $sampled(exp_rdata));
        end

    assert property (@(posedge seq) (t_frame && bit_strobe) |-> tx_line == exp_bit)
        else begin
            err_count++;
            $display("** Error at %0t ns: tx frame bit %0d = %b, expected %b",
                     $time, $sampled(bit_index), $sampled(tx_line), $sampled(exp_bit));
        end

    assert property (@(posedge seq) t_idle |-> tx_line)
        else begin
            err_count++;
            $display("** Error at %0t ns: tx = 0, expected 1 between frames", $time);
        end

    assert property (@(posedge seq) t_irq |-> irq == exp_irq)
        else begin
            err_count++;
            $display("** Error at %0t ns: irq = %b, expected %b",
                     $time, $sampled(irq), $sampled(exp_irq));
        end

    assert property (@(posedge seq) (t_pause && pause_ack) |-> !irq)
        else begin
            err_count++;
            $display("** Error at %0t ns: irq = 1, expected 0 while paused", $time);
        end

    function automatic logic [31:0] apply_strobes(input logic [31:0] value,
                                                  input logic [31:0] old,
                                                  input logic [3:0]  strb);
        logic [31:0] merged;
        merged = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                merged[i*8 +: 8] = value[i*8 +: 8];
            end
        end
        return merged;
    endfunction

    function automatic logic [31:0] len_mask();
        return (32'd1 << cur_len) - 32'd1;
    endfunction

    task automatic idle(input int n);
        repeat (n) @(posedge seq);
        #1;
    endtask

    // Access phase, held until the slave answers
    task automatic complete_transfer(output logic [31:0] data);
        @(posedge seq);
        #1;
        penable = 1'b1;
        while (!pready) begin
            @(posedge seq);
            #1;
        end
        data = prdata;
        @(posedge seq);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        chk_rd  = 1'b0;
        chk_err = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] idx, input logic [31:0] data,
                             input logic [3:0] strb, input logic err);
        logic [31:0] unused;
        exp_err = err;
        chk_err = 1'b1;
        paddr   = {18'd0, idx, 2'b00};
        pwdata  = data;
        pstrb   = strb;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        complete_transfer(unused);
    endtask

    task automatic apb_read(input logic [11:0] idx, input logic [31:0] expected,
                            input logic check, input logic err, output logic [31:0] data);
        chk_rd    = check;
        exp_rdata = expected;
        exp_err   = err;
        chk_err   = 1'b1;
        paddr     = {18'd0, idx, 2'b00};
        pwrite    = 1'b0;
        psel      = 1'b1;
        penable   = 1'b0;
        complete_transfer(data);
    endtask

    task automatic configure_line(input int len, input logic par, input logic odd,
                                  input logic stop2);
        logic [31:0] word;
        logic [31:0] got;
        word = '0;
        word[uart_pkg::CR_ENABLE]  = 1'b1;
        word[uart_pkg::CR_TX_EN]   = 1'b1;
        word[uart_pkg::CR_RX_EN]   = 1'b1;
        word[uart_pkg::CR_PAR_EN]  = par;
        word[uart_pkg::CR_PAR_ODD] = odd;
        word[uart_pkg::CR_STOP2]   = stop2;
        word[uart_pkg::CR_LEN_LSB +: 4] = 4'(len);
        cur_len   = len;
        cur_par   = par;
        cur_odd   = odd;
        cur_stop2 = stop2;
        apb_write(uart_pkg::CR, word, 4'hF, 1'b0);  // May wait for the engines to park
        apb_read(uart_pkg::CR, word, 1'b1, 1'b0, got);
    endtask

    task automatic wait_rx_full();
        logic [31:0] status;
        status = '0;
        while (!status[1]) begin
            apb_read(uart_pkg::SR, 32'd0, 1'b0, 1'b0, status);
        end
    endtask

    // Called on the first cycle of the start bit, samples each bit at its middle
    task automatic check_frame(input logic [31:0] data);
        logic [15:0] bits;
        logic        par;
        int          n;
        bits = '1;  // Stop bits come from the fill
        par  = cur_odd;
        bits[0] = 1'b0;
        n = 1;
        for (int i = 0; i < cur_len; i++) begin
            bits[n] = data[i];
            par = par ^ data[i];
            n++;
        end
        if (cur_par) begin
            bits[n] = par;
            n++;
        end
        n = n + (cur_stop2 ? 2 : 1);
        while (tx_line !== 1'b0) begin
            @(posedge seq);
            #1;
        end
        t_frame = 1'b1;
        repeat (BIT_CYCLES / 2) @(posedge seq);
        #1;
        for (int k = 0; k < n; k++) begin
            bit_index  = k;
            exp_bit    = bits[k];
            bit_strobe = 1'b1;
            @(posedge seq);
            #1;
            bit_strobe = 1'b0;
            repeat (BIT_CYCLES - 1) @(posedge seq);
            #1;
        end
        t_frame = 1'b0;
    endtask

    task automatic loopback_word();
        logic [31:0] data;
        logic [31:0] got;
        data = $random(seed);
        apb_write(uart_pkg::DR, data, 4'hF, 1'b0);
        check_frame(data);
        wait_rx_full();
        apb_read(uart_pkg::DR, data & len_mask(), 1'b1, 1'b0, got);
        t_idle = 1'b1;
        idle(4);
        t_idle = 1'b0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_count != err_mark) begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, err_count - err_mark);
        end else begin
            $display("%s: ok", name);
        end
        err_mark = err_count;
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] got;
        logic [31:0] a;
        logic [31:0] b;
        reset     = 1'b1;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        pstrb     = '0;
        pause_req = 1'b0;
        repeat (8) @(posedge seq);
        #1;
        reset = 1'b0;
        idle(2);

        rnd = $random(seed);
        apb_write(uart_pkg::BRR, rnd, 4'b0101, 1'b0);
        apb_read(uart_pkg::BRR, apply_strobes(rnd, 32'd0, 4'b0101), 1'b1, 1'b0, got);
        rnd = $random(seed);
        apb_write(uart_pkg::IER, rnd, 4'b1010, 1'b0);
        apb_read(uart_pkg::IER, apply_strobes(rnd, 32'd0, 4'b1010), 1'b1, 1'b0, got);
        rnd = $random(seed);
        apb_write(uart_pkg::CR, rnd, 4'b0010, 1'b0);  // Length lane only, stays disabled
        apb_read(uart_pkg::CR, apply_strobes(rnd, 32'd0, 4'b0010), 1'b1, 1'b0, got);
        apb_write(uart_pkg::CR, 32'd0, 4'hF, 1'b0);
        apb_write(uart_pkg::IER, 32'd0, 4'hF, 1'b0);
        apb_write(uart_pkg::BRR, BRR_VAL, 4'hF, 1'b0);
        end_test("register access");

        configure_line(8, 1'b0, 1'b0, 1'b0);
        apb_read(uart_pkg::DR, 32'd0, 1'b0, 1'b1, got);  // Nothing received yet
        rnd = $random(seed);
        apb_write(uart_pkg::SR, rnd, 4'hF, 1'b1);
        apb_write(12'd5, rnd, 4'hF, 1'b1);
        apb_read(12'd5, 32'd0, 1'b0, 1'b1, got);
        a = $random(seed);
        b = $random(seed);
        apb_write(uart_pkg::DR, a, 4'hF, 1'b0);  // Engine takes it at once
        apb_write(uart_pkg::DR, b, 4'hF, 1'b0);
        apb_write(uart_pkg::DR, rnd, 4'hF, 1'b1);  // b still buffered
        wait_rx_full();
        apb_read(uart_pkg::DR, a & 32'hFF, 1'b1, 1'b0, got);
        wait_rx_full();
        apb_read(uart_pkg::DR, b & 32'hFF, 1'b1, 1'b0, got);
        end_test("error responses");

        repeat (4) loopback_word();
        end_test("loopback 8N1");

        configure_line(7, 1'b1, 1'b1, 1'b1);  // Live change while enabled
        repeat (4) loopback_word();
        end_test("loopback 7O2");

        apb_write(uart_pkg::IER, 32'd1, 4'hF, 1'b0);
        exp_irq = 1'b1;
        t_irq   = 1'b1;
        idle(4);
        t_irq = 1'b0;
        apb_write(uart_pkg::IER, 32'd2, 4'hF, 1'b0);
        exp_irq = 1'b0;
        t_irq   = 1'b1;
        idle(4);
        t_irq = 1'b0;
        rnd = $random(seed);
        apb_write(uart_pkg::DR, rnd, 4'hF, 1'b0);
        wait_rx_full();
        exp_irq = 1'b1;
        t_irq   = 1'b1;
        idle(4);
        t_irq = 1'b0;
        apb_read(uart_pkg::DR, rnd & len_mask(), 1'b1, 1'b0, got);
        exp_irq = 1'b0;
        t_irq   = 1'b1;
        idle(4);
        t_irq = 1'b0;
        end_test("interrupt");

        apb_write(uart_pkg::IER, 32'd1, 4'hF, 1'b0);  // irq would be high if not paused
        pause_req = 1'b1;
        t_pause   = 1'b1;
        while (!pause_ack) begin
            @(posedge seq);
            #1;
        end
        apb_read(uart_pkg::CR, 32'd0, 1'b0, 1'b1, got);
        apb_write(uart_pkg::BRR, 32'd3, 4'hF, 1'b1);
        pause_req = 1'b0;
        while (pause_ack) begin
            @(posedge seq);
            #1;
        end
        t_pause = 1'b0;
        loopback_word();  // Also shows BRR kept its value
        end_test("external pause");

        $display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
source/uart_pkg.sv
source/uart_cfg_if.sv
source/uart_regs.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_periph.sv
verification/uart_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module uart_tb -o uart_tb
	./obj_dir/uart_tb | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
